// ==== verilog/mhu_pkg.sv ====
package mhu_pkg;

  // Cache geometry
  localparam int ways_lp = 4;
  localparam int sets_lp = 16;
  localparam int block_words_lp = 4;
  localparam int data_width_lp = 32;
  localparam int addr_width_lp = 32;
  localparam int id_width_lp = 4;

  localparam int lg_ways_lp = $clog2(ways_lp);
  localparam int lg_sets_lp = $clog2(sets_lp);
  localparam int lg_block_words_lp = $clog2(block_words_lp);
  localparam int byte_sel_width_lp = $clog2(data_width_lp / 8);
  localparam int tag_width_lp =
    addr_width_lp - lg_sets_lp - lg_block_words_lp - byte_sel_width_lp;

  // Address fields, from the low end up
  localparam int word_lsb_lp = byte_sel_width_lp;
  localparam int index_lsb_lp = word_lsb_lp + lg_block_words_lp;
  localparam int tag_lsb_lp = index_lsb_lp + lg_sets_lp;

  typedef logic [lg_ways_lp-1:0] way_t;
  typedef logic [lg_sets_lp-1:0] index_t;
  typedef logic [tag_width_lp-1:0] tag_t;
  typedef logic [lg_block_words_lp-1:0] word_off_t;

  // Bit 0 is the root, bit 1 picks within ways 0-1, bit 2 within ways 2-3
  typedef logic [ways_lp-2:0] lru_t;

  typedef enum logic [2:0] {
    IDLE,
    READ_TAG,
    SEND_DMA,
    WAIT_DMA,
    DRAIN
  } mhu_state_e;

endpackage

// ==== verilog/replacement_picker.sv ====
`timescale 1ns/1ps

module replacement_picker (
  input  logic [mhu_pkg::ways_lp-1:0] tag_valid_i
  , input  logic [mhu_pkg::ways_lp-1:0] tag_lock_i
  , input  logic [mhu_pkg::ways_lp-1:0] dirty_i
  , input  mhu_pkg::tag_t [mhu_pkg::ways_lp-1:0] tag_tags_i
  , input  mhu_pkg::lru_t lru_bits_i
  , output mhu_pkg::way_t victim_way_o
  , output logic victim_evict_o
  , output mhu_pkg::tag_t victim_tag_o
);

  logic [mhu_pkg::ways_lp-1:0] free_ways;
  logic free_found;
  mhu_pkg::way_t free_way;
  logic lo_locked;
  logic hi_locked;
  logic lru_root;
  mhu_pkg::way_t lru_leaf;
  mhu_pkg::way_t lru_way;

  // Invalid and unlocked ways are taken first
  assign free_ways = ~tag_valid_i & ~tag_lock_i;

  // Scan from the top so the lowest free way wins
  always_comb begin
    free_found = 1'b0;
    free_way = '0;
    for (int w = mhu_pkg::ways_lp - 1; w >= 0; w--) begin
      if (free_ways[w]) begin
        free_found = 1'b1;
        free_way = mhu_pkg::way_t'(w);
      end
    end
  end

  // A fully locked half forces the root toward the other half
  assign lo_locked = tag_lock_i[0] & tag_lock_i[1];
  assign hi_locked = tag_lock_i[2] & tag_lock_i[3];

  always_comb begin
    if (lo_locked) begin
      lru_root = 1'b1;
    end else if (hi_locked) begin
      lru_root = 1'b0;
    end else begin
      lru_root = lru_bits_i[0];
    end
  end

  assign lru_leaf = {lru_root, lru_root ? lru_bits_i[2] : lru_bits_i[1]};

  // Locked leaf falls back to its sibling, which the root choice keeps unlocked
  assign lru_way = tag_lock_i[lru_leaf] ? {lru_leaf[1], ~lru_leaf[0]} : lru_leaf;

  assign victim_way_o = free_found ? free_way : lru_way;
  assign victim_evict_o = tag_valid_i[victim_way_o] & dirty_i[victim_way_o];
  assign victim_tag_o = tag_tags_i[victim_way_o];

  // Set state comes from the tag memory; a fully locked set has no legal victim
  always_comb begin
    assert ((&tag_lock_i) !== 1'b1)
      else $error("replacement_picker: all ways of the set are locked");
  end

endmodule

// ==== verilog/miss_drain.sv ====
`timescale 1ns/1ps

module miss_drain (
  input  logic clk_i
  , input  logic reset_i
  , input  logic drain_active_i
  , input  mhu_pkg::way_t curr_way_i
  , input  mhu_pkg::index_t curr_index_i
  , input  mhu_pkg::tag_t curr_tag_i

  , input  logic miss_v_i
  , input  logic [mhu_pkg::addr_width_lp-1:0] miss_addr_i
  , input  logic miss_write_i
  , input  logic [mhu_pkg::data_width_lp-1:0] miss_data_i
  , input  logic miss_block_i
  , input  logic [mhu_pkg::id_width_lp-1:0] miss_id_i
  , output logic miss_ready_o

  , output logic data_v_o
  , input  logic data_ready_i
  , output logic data_write_o
  , output mhu_pkg::way_t data_way_o
  , output mhu_pkg::index_t data_index_o
  , output mhu_pkg::word_off_t data_word_o
  , output logic [mhu_pkg::data_width_lp-1:0] data_o
  , output logic [mhu_pkg::id_width_lp-1:0] data_id_o

  , output logic drain_end_o
  , output logic drain_dirty_o
);

  mhu_pkg::tag_t head_tag;
  mhu_pkg::index_t head_index;
  mhu_pkg::word_off_t head_word;
  mhu_pkg::word_off_t word_cnt_r;
  logic secondary;
  logic beat;
  logic last_beat;
  logic dirty_r;

  assign head_tag = miss_addr_i[mhu_pkg::tag_lsb_lp +: mhu_pkg::tag_width_lp];
  assign head_index = miss_addr_i[mhu_pkg::index_lsb_lp +: mhu_pkg::lg_sets_lp];
  assign head_word = miss_addr_i[mhu_pkg::word_lsb_lp +: mhu_pkg::lg_block_words_lp];

  // Head hits the block that was just refilled
  assign secondary = miss_v_i & (head_tag == curr_tag_i) & (head_index == curr_index_i);

  // Replay toward data memory in the refilled way
  assign data_v_o = drain_active_i & secondary;
  assign data_write_o = miss_write_i;
  assign data_way_o = curr_way_i;
  assign data_index_o = curr_index_i;
  assign data_word_o = miss_block_i ? word_cnt_r : head_word;
  assign data_o = miss_data_i;
  assign data_id_o = miss_id_i;

  assign beat = data_v_o & data_ready_i;
  assign last_beat = ~miss_block_i
    | (word_cnt_r == mhu_pkg::word_off_t'(mhu_pkg::block_words_lp - 1));

  // Pop only on the final beat of an entry
  assign miss_ready_o = beat & last_beat;

  assign drain_end_o = drain_active_i & ~secondary;
  assign drain_dirty_o = dirty_r;

  // Word counter and dirty flag start fresh with every drain
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      word_cnt_r <= '0;
      dirty_r <= 1'b0;
    end else if (!drain_active_i) begin
      word_cnt_r <= '0;
      dirty_r <= 1'b0;
    end else begin
      if (beat && miss_block_i) begin
        word_cnt_r <= last_beat ? '0 : word_cnt_r + 1'b1;
      end
      if (beat && miss_write_i) begin
        dirty_r <= 1'b1;
      end
    end
  end

  // Stalled request holds until accepted, which needs the queue head to hold too
  assert property (@(posedge clk_i) disable iff (reset_i)
    data_v_o && !data_ready_i |=> data_v_o
      && $stable({data_write_o, data_way_o, data_index_o, data_word_o, data_o, data_id_o}))
    else $error("miss_drain: data request changed under back-pressure");

endmodule

// ==== verilog/mhu_fsm.sv ====
`timescale 1ns/1ps

module mhu_fsm (
  input  logic clk_i
  , input  logic reset_i
  , input  logic miss_v_i
  , input  logic [mhu_pkg::addr_width_lp-1:0] miss_addr_i

  , input  logic [mhu_pkg::ways_lp-1:0] tag_valid_i
  , input  logic [mhu_pkg::ways_lp-1:0] tag_lock_i
  , input  mhu_pkg::tag_t [mhu_pkg::ways_lp-1:0] tag_tags_i
  , input  mhu_pkg::lru_t lru_bits_i
  , input  logic [mhu_pkg::ways_lp-1:0] dirty_i

  , input  logic dma_cmd_ready_i
  , input  logic dma_done_i
  , input  logic drain_end_i
  , input  logic drain_dirty_i
  , input  mhu_pkg::way_t victim_way_i
  , input  logic victim_evict_i
  , input  mhu_pkg::tag_t victim_tag_i

  , output logic idle_o
  , output logic tag_read_v_o
  , output mhu_pkg::index_t tag_read_index_o

  , output logic [mhu_pkg::ways_lp-1:0] cap_valid_o
  , output logic [mhu_pkg::ways_lp-1:0] cap_lock_o
  , output logic [mhu_pkg::ways_lp-1:0] cap_dirty_o
  , output mhu_pkg::tag_t [mhu_pkg::ways_lp-1:0] cap_tags_o
  , output mhu_pkg::lru_t cap_lru_o

  , output logic tag_write_v_o
  , output mhu_pkg::way_t tag_write_way_o
  , output mhu_pkg::index_t tag_write_index_o
  , output mhu_pkg::tag_t tag_write_tag_o
  , output logic stat_write_v_o
  , output mhu_pkg::way_t stat_write_way_o
  , output mhu_pkg::index_t stat_write_index_o
  , output logic stat_set_dirty_o

  , output logic dma_cmd_v_o
  , output mhu_pkg::way_t dma_cmd_way_o
  , output mhu_pkg::index_t dma_cmd_index_o
  , output mhu_pkg::tag_t dma_cmd_refill_tag_o
  , output logic dma_cmd_evict_o
  , output mhu_pkg::tag_t dma_cmd_evict_tag_o
  , output logic dma_ack_o

  , output logic drain_active_o
  , output mhu_pkg::way_t curr_way_o
  , output mhu_pkg::index_t curr_index_o
  , output mhu_pkg::tag_t curr_tag_o
);

  mhu_pkg::mhu_state_e state_r;
  mhu_pkg::mhu_state_e state_n;

  // Set state as read from tag and status memory
  logic [mhu_pkg::ways_lp-1:0] valid_r;
  logic [mhu_pkg::ways_lp-1:0] lock_r;
  logic [mhu_pkg::ways_lp-1:0] dirty_r;
  mhu_pkg::tag_t [mhu_pkg::ways_lp-1:0] tags_r;
  mhu_pkg::lru_t lru_r;

  // Current miss
  mhu_pkg::way_t curr_way_r;
  mhu_pkg::index_t curr_index_r;
  mhu_pkg::tag_t curr_tag_r;

  logic start_miss;
  logic dma_fire;
  logic drain_done;

  assign start_miss = (state_r == mhu_pkg::IDLE) & miss_v_i;
  assign dma_fire = dma_cmd_v_o & dma_cmd_ready_i;
  assign drain_done = (state_r == mhu_pkg::DRAIN) & drain_end_i;

  always_comb begin
    state_n = state_r;
    case (state_r)
      mhu_pkg::IDLE: begin
        if (miss_v_i) state_n = mhu_pkg::READ_TAG;
      end
      mhu_pkg::READ_TAG: state_n = mhu_pkg::SEND_DMA;
      mhu_pkg::SEND_DMA: begin
        if (dma_cmd_ready_i) state_n = mhu_pkg::WAIT_DMA;
      end
      mhu_pkg::WAIT_DMA: begin
        if (dma_done_i) state_n = mhu_pkg::DRAIN;
      end
      mhu_pkg::DRAIN: begin
        if (drain_end_i) state_n = mhu_pkg::IDLE;
      end
      default: state_n = mhu_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= mhu_pkg::IDLE;
    end else begin
      state_r <= state_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_miss) begin
      curr_index_r <= tag_read_index_o;
      curr_tag_r <= miss_addr_i[mhu_pkg::tag_lsb_lp +: mhu_pkg::tag_width_lp];
    end
    // Memory answers one cycle after the read request
    if (state_r == mhu_pkg::READ_TAG) begin
      valid_r <= tag_valid_i;
      lock_r <= tag_lock_i;
      dirty_r <= dirty_i;
      tags_r <= tag_tags_i;
      lru_r <= lru_bits_i;
    end
    if (dma_fire) curr_way_r <= victim_way_i;
  end

  assign idle_o = (state_r == mhu_pkg::IDLE) & ~miss_v_i;
  assign tag_read_v_o = start_miss;
  assign tag_read_index_o = miss_addr_i[mhu_pkg::index_lsb_lp +: mhu_pkg::lg_sets_lp];

  assign cap_valid_o = valid_r;
  assign cap_lock_o = lock_r;
  assign cap_dirty_o = dirty_r;
  assign cap_tags_o = tags_r;
  assign cap_lru_o = lru_r;

  // Refill and evict in one command
  assign dma_cmd_v_o = (state_r == mhu_pkg::SEND_DMA);
  assign dma_cmd_way_o = victim_way_i;
  assign dma_cmd_index_o = curr_index_r;
  assign dma_cmd_refill_tag_o = curr_tag_r;
  assign dma_cmd_evict_o = victim_evict_i;
  assign dma_cmd_evict_tag_o = victim_tag_i;
  assign dma_ack_o = (state_r == mhu_pkg::WAIT_DMA) & dma_done_i;

  // Tag and status update close the drain
  assign tag_write_v_o = drain_done;
  assign tag_write_way_o = curr_way_r;
  assign tag_write_index_o = curr_index_r;
  assign tag_write_tag_o = curr_tag_r;
  assign stat_write_v_o = drain_done;
  assign stat_write_way_o = curr_way_r;
  assign stat_write_index_o = curr_index_r;
  assign stat_set_dirty_o = drain_dirty_i;

  assign drain_active_o = (state_r == mhu_pkg::DRAIN);
  assign curr_way_o = curr_way_r;
  assign curr_index_o = curr_index_r;
  assign curr_tag_o = curr_tag_r;

  // Picker output must never land on a locked way
  assert property (@(posedge clk_i) disable iff (reset_i)
    dma_cmd_v_o |-> !lock_r[dma_cmd_way_o])
    else $error("mhu_fsm: DMA command targets a locked way");

  assert property (@(posedge clk_i) disable iff (reset_i)
    dma_cmd_v_o && !dma_cmd_ready_i |=> dma_cmd_v_o
      && $stable({dma_cmd_way_o, dma_cmd_index_o, dma_cmd_refill_tag_o,
                  dma_cmd_evict_o, dma_cmd_evict_tag_o}))
    else $error("mhu_fsm: DMA command changed while stalled");

endmodule

// ==== verilog/miss_handling_unit.sv ====
`timescale 1ns/1ps

module miss_handling_unit (
  input  logic clk_i
  , input  logic reset_i
  , output logic idle_o

  // Miss queue head
  , input  logic miss_v_i
  , input  logic [mhu_pkg::addr_width_lp-1:0] miss_addr_i
  , input  logic miss_write_i
  , input  logic [mhu_pkg::data_width_lp-1:0] miss_data_i
  , input  logic miss_block_i
  , input  logic [mhu_pkg::id_width_lp-1:0] miss_id_i
  , output logic miss_ready_o

  // Tag and status memory
  , output logic tag_read_v_o
  , output mhu_pkg::index_t tag_read_index_o
  , input  logic [mhu_pkg::ways_lp-1:0] tag_valid_i
  , input  logic [mhu_pkg::ways_lp-1:0] tag_lock_i
  , input  mhu_pkg::tag_t [mhu_pkg::ways_lp-1:0] tag_tags_i
  , input  mhu_pkg::lru_t lru_bits_i
  , input  logic [mhu_pkg::ways_lp-1:0] dirty_i
  , output logic tag_write_v_o
  , output mhu_pkg::way_t tag_write_way_o
  , output mhu_pkg::index_t tag_write_index_o
  , output mhu_pkg::tag_t tag_write_tag_o
  , output logic stat_write_v_o
  , output mhu_pkg::way_t stat_write_way_o
  , output mhu_pkg::index_t stat_write_index_o
  , output logic stat_set_dirty_o

  // DMA
  , output logic dma_cmd_v_o
  , input  logic dma_cmd_ready_i
  , output mhu_pkg::way_t dma_cmd_way_o
  , output mhu_pkg::index_t dma_cmd_index_o
  , output mhu_pkg::tag_t dma_cmd_refill_tag_o
  , output logic dma_cmd_evict_o
  , output mhu_pkg::tag_t dma_cmd_evict_tag_o
  , input  logic dma_done_i
  , output logic dma_ack_o

  // Data memory
  , output logic data_v_o
  , input  logic data_ready_i
  , output logic data_write_o
  , output mhu_pkg::way_t data_way_o
  , output mhu_pkg::index_t data_index_o
  , output mhu_pkg::word_off_t data_word_o
  , output logic [mhu_pkg::data_width_lp-1:0] data_o
  , output logic [mhu_pkg::id_width_lp-1:0] data_id_o
);

  logic [mhu_pkg::ways_lp-1:0] cap_valid;
  logic [mhu_pkg::ways_lp-1:0] cap_lock;
  logic [mhu_pkg::ways_lp-1:0] cap_dirty;
  mhu_pkg::tag_t [mhu_pkg::ways_lp-1:0] cap_tags;
  mhu_pkg::lru_t cap_lru;
  mhu_pkg::way_t victim_way;
  logic victim_evict;
  mhu_pkg::tag_t victim_tag;
  logic drain_active;
  logic drain_end;
  logic drain_dirty;
  mhu_pkg::way_t curr_way;
  mhu_pkg::index_t curr_index;
  mhu_pkg::tag_t curr_tag;

  mhu_fsm fsm_inst (
    .*
    , .cap_valid_o(cap_valid)
    , .cap_lock_o(cap_lock)
    , .cap_dirty_o(cap_dirty)
    , .cap_tags_o(cap_tags)
    , .cap_lru_o(cap_lru)
    , .drain_end_i(drain_end)
    , .drain_dirty_i(drain_dirty)
    , .victim_way_i(victim_way)
    , .victim_evict_i(victim_evict)
    , .victim_tag_i(victim_tag)
    , .drain_active_o(drain_active)
    , .curr_way_o(curr_way)
    , .curr_index_o(curr_index)
    , .curr_tag_o(curr_tag)
  );

  // Victim comes from the captured set, not the live memory outputs
  replacement_picker picker_inst (
    .tag_valid_i(cap_valid)
    , .tag_lock_i(cap_lock)
    , .dirty_i(cap_dirty)
    , .tag_tags_i(cap_tags)
    , .lru_bits_i(cap_lru)
    , .victim_way_o(victim_way)
    , .victim_evict_o(victim_evict)
    , .victim_tag_o(victim_tag)
  );

  miss_drain drain_inst (
    .*
    , .drain_active_i(drain_active)
    , .curr_way_i(curr_way)
    , .curr_index_i(curr_index)
    , .curr_tag_i(curr_tag)
    , .drain_end_o(drain_end)
    , .drain_dirty_o(drain_dirty)
  );

endmodule

// ==== verification/mhu_tb_assertions.svh ====
// Victim rule: lowest invalid unlocked way, else the pseudo-LRU tree around locks
function automatic mhu_pkg::way_t ref_victim(input logic [mhu_pkg::ways_lp-1:0] valid,
                                             input logic [mhu_pkg::ways_lp-1:0] lock,
                                             input mhu_pkg::lru_t lru);
  mhu_pkg::way_t way;
  logic found;
  logic half;
  found = 1'b0;
  way = '0;
  for (int w = 0; w < mhu_pkg::ways_lp; w++) begin
    if (!found && !valid[w] && !lock[w]) begin
      way = mhu_pkg::way_t'(w);
      found = 1'b1;
    end
  end
  if (!found) begin
    half = lru[0];
    if (lock[1:0] == 2'b11) half = 1'b1;
    else if (lock[3:2] == 2'b11) half = 1'b0;
    way = {half, half ? lru[2] : lru[1]};
    if (lock[way]) way[0] = ~way[0];
  end
  return way;
endfunction

// LRU tree points away from the way just written
function automatic mhu_pkg::lru_t lru_after(input mhu_pkg::lru_t lru, input mhu_pkg::way_t way);
  mhu_pkg::lru_t next;
  next = lru;
  next[0] = ~way[1];
  if (way[1]) next[2] = ~way[0];
  else next[1] = ~way[0];
  return next;
endfunction

assert property (@(posedge clk_i) $fell(reset_i) |-> idle_o && !(tag_read_v_o || tag_write_v_o
  || stat_write_v_o || dma_cmd_v_o || dma_ack_o || data_v_o || miss_ready_o))
  else report_fail("outputs not quiet or idle_o low after reset");

// Tag read of the missing set
assert property (@(posedge clk_i) disable iff (reset_i)
  tag_read_v_o |-> tag_read_index_o == head_index)
  else report_value("tag_read_index_o", 64'($sampled(tag_read_index_o)),
                    64'($sampled(head_index)));

// Refill and evict command
assert property (@(posedge clk_i) disable iff (reset_i) dma_cmd_v_o |-> dma_cmd_way_o == exp_way)
  else report_value("dma_cmd_way_o", 64'($sampled(dma_cmd_way_o)), 64'($sampled(exp_way)));
assert property (@(posedge clk_i) disable iff (reset_i)
  dma_cmd_v_o |-> dma_cmd_evict_o == exp_evict)
  else report_value("dma_cmd_evict_o", 64'($sampled(dma_cmd_evict_o)), 64'($sampled(exp_evict)));
assert property (@(posedge clk_i) disable iff (reset_i)
  dma_cmd_v_o && exp_evict |-> dma_cmd_evict_tag_o == exp_evict_tag)
  else report_value("dma_cmd_evict_tag_o", 64'($sampled(dma_cmd_evict_tag_o)),
                    64'($sampled(exp_evict_tag)));
assert property (@(posedge clk_i) disable iff (reset_i)
  dma_cmd_v_o |-> {dma_cmd_refill_tag_o, dma_cmd_index_o} == {exp_tag, exp_index})
  else report_value("dma_cmd_refill_tag_o/dma_cmd_index_o",
                    64'($sampled({dma_cmd_refill_tag_o, dma_cmd_index_o})),
                    64'($sampled({exp_tag, exp_index})));
assert property (@(posedge clk_i) disable iff (reset_i)
  dma_cmd_v_o && !dma_cmd_ready_i |=> dma_cmd_v_o && $stable({dma_cmd_way_o, dma_cmd_index_o,
    dma_cmd_refill_tag_o, dma_cmd_evict_o, dma_cmd_evict_tag_o}))
  else report_fail("DMA command changed before it was accepted");
assert property (@(posedge clk_i) disable iff (reset_i) dma_done_i |-> dma_ack_o)
  else report_value("dma_ack_o", 64'($sampled(dma_ack_o)), 64'(1));

// Replay of secondary misses
assert property (@(posedge clk_i) disable iff (reset_i) data_v_o == exp_data_v)
  else report_value("data_v_o", 64'($sampled(data_v_o)), 64'($sampled(exp_data_v)));
assert property (@(posedge clk_i) disable iff (reset_i)
  data_v_o |-> {data_way_o, data_index_o} == {exp_way, exp_index})
  else report_value("data_way_o/data_index_o", 64'($sampled({data_way_o, data_index_o})),
                    64'($sampled({exp_way, exp_index})));
assert property (@(posedge clk_i) disable iff (reset_i) data_v_o |-> data_word_o == exp_word)
  else report_value("data_word_o", 64'($sampled(data_word_o)), 64'($sampled(exp_word)));
assert property (@(posedge clk_i) disable iff (reset_i)
  data_v_o |-> {data_write_o, data_o, data_id_o} == {miss_write_i, miss_data_i, miss_id_i})
  else report_value("data_write_o/data_o/data_id_o",
                    64'($sampled({data_write_o, data_o, data_id_o})),
                    64'($sampled({miss_write_i, miss_data_i, miss_id_i})));
assert property (@(posedge clk_i) disable iff (reset_i) miss_ready_o == exp_pop)
  else report_value("miss_ready_o", 64'($sampled(miss_ready_o)), 64'($sampled(exp_pop)));
assert property (@(posedge clk_i) disable iff (reset_i)
  data_v_o && !data_ready_i |=> data_v_o
    && $stable({data_write_o, data_way_o, data_index_o, data_word_o, data_o, data_id_o}))
  else report_fail("data request changed before it was accepted");

// Tag and status update at the drain end
assert property (@(posedge clk_i) disable iff (reset_i)
  {tag_write_v_o, stat_write_v_o} == {2{exp_drain_end}})
  else report_value("tag_write_v_o/stat_write_v_o", 64'($sampled({tag_write_v_o, stat_write_v_o})),
                    64'($sampled({2{exp_drain_end}})));
assert property (@(posedge clk_i) disable iff (reset_i)
  tag_write_v_o |-> {tag_write_tag_o, tag_write_way_o, tag_write_index_o, stat_write_way_o,
    stat_write_index_o, stat_set_dirty_o} == {exp_tag, exp_way, exp_index, exp_way, exp_index,
    exp_dirty})
  else report_value("tag_write_tag_o/way/index/stat_write_way_o/index/stat_set_dirty_o",
                    64'($sampled({tag_write_tag_o, tag_write_way_o, tag_write_index_o,
                                  stat_write_way_o, stat_write_index_o, stat_set_dirty_o})),
                    64'($sampled({exp_tag, exp_way, exp_index, exp_way, exp_index, exp_dirty})));
assert property (@(posedge clk_i) disable iff (reset_i)
  tag_write_v_o && miss_v_i |=> tag_read_v_o)
  else report_fail("next queue head did not start a tag read after the drain");

// ==== verification/mhu_tb.sv ====
`timescale 1ns/1ps

module mhu_tb;

  logic clk_i;
  logic reset_i;
  logic idle_o;
  logic miss_v_i;
  logic [mhu_pkg::addr_width_lp-1:0] miss_addr_i;
  logic miss_write_i;
  logic [mhu_pkg::data_width_lp-1:0] miss_data_i;
  logic miss_block_i;
  logic [mhu_pkg::id_width_lp-1:0] miss_id_i;
  logic miss_ready_o;
  logic tag_read_v_o;
  mhu_pkg::index_t tag_read_index_o;
  logic [mhu_pkg::ways_lp-1:0] tag_valid_i;
  logic [mhu_pkg::ways_lp-1:0] tag_lock_i;
  mhu_pkg::tag_t [mhu_pkg::ways_lp-1:0] tag_tags_i;
  mhu_pkg::lru_t lru_bits_i;
  logic [mhu_pkg::ways_lp-1:0] dirty_i;
  logic tag_write_v_o;
  mhu_pkg::way_t tag_write_way_o;
  mhu_pkg::index_t tag_write_index_o;
  mhu_pkg::tag_t tag_write_tag_o;
  logic stat_write_v_o;
  mhu_pkg::way_t stat_write_way_o;
  mhu_pkg::index_t stat_write_index_o;
  logic stat_set_dirty_o;
  logic dma_cmd_v_o;
  logic dma_cmd_ready_i;
  mhu_pkg::way_t dma_cmd_way_o;
  mhu_pkg::index_t dma_cmd_index_o;
  mhu_pkg::tag_t dma_cmd_refill_tag_o;
  logic dma_cmd_evict_o;
  mhu_pkg::tag_t dma_cmd_evict_tag_o;
  logic dma_done_i;
  logic dma_ack_o;
  logic data_v_o;
  logic data_ready_i;
  logic data_write_o;
  mhu_pkg::way_t data_way_o;
  mhu_pkg::index_t data_index_o;
  mhu_pkg::word_off_t data_word_o;
  logic [mhu_pkg::data_width_lp-1:0] data_o;
  logic [mhu_pkg::id_width_lp-1:0] data_id_o;

  // Queue entry is {addr, write, data, block, id}
  logic [mhu_pkg::addr_width_lp+mhu_pkg::data_width_lp+mhu_pkg::id_width_lp+1:0] queue[$];

  // Tag and status memory
  logic [mhu_pkg::ways_lp-1:0] valid_mem [mhu_pkg::sets_lp];
  logic [mhu_pkg::ways_lp-1:0] lock_mem [mhu_pkg::sets_lp];
  logic [mhu_pkg::ways_lp-1:0] dirty_mem [mhu_pkg::sets_lp];
  mhu_pkg::tag_t [mhu_pkg::ways_lp-1:0] tags_mem [mhu_pkg::sets_lp];
  mhu_pkg::lru_t lru_mem [mhu_pkg::sets_lp];
  mhu_pkg::index_t rd_idx;

  // Expected current miss
  mhu_pkg::way_t exp_way;
  mhu_pkg::index_t exp_index;
  mhu_pkg::tag_t exp_tag;
  mhu_pkg::tag_t exp_evict_tag;
  logic exp_evict;
  logic exp_dirty;
  logic in_drain;
  mhu_pkg::word_off_t beat_cnt;

  int seed = 32'h23b8_c9c9;
  int errors;
  int tests;
  int dma_wait;
  logic dma_busy;
  logic bp_en;
  logic timed_out;

  mhu_pkg::tag_t head_tag;
  mhu_pkg::index_t head_index;
  logic head_secondary;
  logic exp_data_v;
  logic exp_pop;
  logic exp_drain_end;
  mhu_pkg::word_off_t exp_word;

  assign head_tag = miss_addr_i[mhu_pkg::tag_lsb_lp +: mhu_pkg::tag_width_lp];
  assign head_index = miss_addr_i[mhu_pkg::index_lsb_lp +: mhu_pkg::lg_sets_lp];
  assign head_secondary = miss_v_i && head_tag == exp_tag && head_index == exp_index;
  assign exp_data_v = in_drain && head_secondary;
  assign exp_drain_end = in_drain && !head_secondary;
  assign exp_word = miss_block_i ? beat_cnt
    : miss_addr_i[mhu_pkg::word_lsb_lp +: mhu_pkg::lg_block_words_lp];
  assign exp_pop = exp_data_v && data_ready_i
    && (!miss_block_i || beat_cnt == mhu_pkg::word_off_t'(mhu_pkg::block_words_lp - 1));

  miss_handling_unit miss_handling_unit_inst (.*);

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  task automatic report_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    $display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    errors++;
  endtask

  task automatic report_fail(input string what);
    $display("error at %0t: %s", $time, what);
    errors++;
  endtask

  task automatic finish_test(input string name, input int err0);
    tests++;
    if (errors == err0) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - err0);
  endtask

  // Queue, memory and DMA models sample at the edge and drive 1 ns later
  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (miss_v_i && miss_ready_o) queue.delete(0);
      if (exp_data_v && data_ready_i) begin
        if (miss_write_i) exp_dirty = 1'b1;
        beat_cnt = exp_pop ? '0 : beat_cnt + 1'b1;
      end
      if (tag_write_v_o) begin
        in_drain = 1'b0;
        tags_mem[tag_write_index_o][tag_write_way_o] = tag_write_tag_o;
        valid_mem[tag_write_index_o][tag_write_way_o] = 1'b1;
      end
      if (stat_write_v_o) begin
        dirty_mem[stat_write_index_o][stat_write_way_o] = stat_set_dirty_o;
        lru_mem[stat_write_index_o] = lru_after(lru_mem[stat_write_index_o], stat_write_way_o);
      end
      if (tag_read_v_o) begin
        rd_idx = tag_read_index_o;
        exp_index = head_index;
        exp_tag = head_tag;
        exp_way = ref_victim(valid_mem[exp_index], lock_mem[exp_index], lru_mem[exp_index]);
        exp_evict = valid_mem[exp_index][exp_way] & dirty_mem[exp_index][exp_way];
        exp_evict_tag = tags_mem[exp_index][exp_way];
      end
      if (dma_done_i && dma_ack_o) begin
        dma_busy = 1'b0;
        in_drain = 1'b1;
        exp_dirty = 1'b0;
        beat_cnt = '0;
      end
      if (dma_cmd_v_o && dma_cmd_ready_i) begin
        dma_busy = 1'b1;
        dma_wait = int'(rnd() % 6);
      end else if (dma_busy && dma_wait > 0) begin
        dma_wait--;
      end
    end
    #1;
    miss_v_i = queue.size() != 0;
    if (miss_v_i) {miss_addr_i, miss_write_i, miss_data_i, miss_block_i, miss_id_i} = queue[0];
    tag_valid_i = valid_mem[rd_idx];
    tag_lock_i = lock_mem[rd_idx];
    tag_tags_i = tags_mem[rd_idx];
    lru_bits_i = lru_mem[rd_idx];
    dirty_i = dirty_mem[rd_idx];
    dma_cmd_ready_i = !bp_en || rnd() % 2 == 0;
    dma_done_i = dma_busy && dma_wait == 0;
    data_ready_i = !bp_en || rnd() % 3 != 0;
  end

  task automatic randomize_sets();
    for (int i = 0; i < mhu_pkg::sets_lp; i++) begin
      valid_mem[i] = 4'(rnd()) | 4'(rnd());
      lock_mem[i] = 4'(rnd()) & 4'(rnd());
      if (&lock_mem[i]) lock_mem[i][0] = 1'b0;
      dirty_mem[i] = 4'(rnd());
      lru_mem[i] = mhu_pkg::lru_t'(rnd());
      for (int w = 0; w < mhu_pkg::ways_lp; w++) begin
        tags_mem[i][w] = mhu_pkg::tag_t'(rnd());
      end
    end
  endtask

  // Block mode 0 has no block loads, 1 only block loads, 2 a random mix
  task automatic run_misses(input string name, input int count, input int block_mode);
    int err0;
    int cycles;
    int nsec;
    mhu_pkg::tag_t tag;
    mhu_pkg::tag_t prev_tag;
    mhu_pkg::index_t idx;
    mhu_pkg::index_t prev_idx;
    logic blk;
    logic [31:0] r;
    if (timed_out) return;
    err0 = errors;
    prev_tag = '0;
    prev_idx = '0;
    randomize_sets();
    for (int m = 0; m < count; m++) begin
      tag = mhu_pkg::tag_t'(rnd());
      idx = mhu_pkg::index_t'(rnd());
      // Back-to-back misses to the same block would merge into one drain
      if (tag == prev_tag && idx == prev_idx) tag = ~tag;
      nsec = int'(rnd() % 4);
      for (int s = 0; s <= nsec; s++) begin
        r = rnd();
        blk = (block_mode == 2) ? (r[0] & r[1]) : (block_mode == 1);
        queue.push_back({tag, idx, r[5:4], 2'b00, ~blk & r[2], rnd(), blk, r[9:6]});
      end
      prev_tag = tag;
      prev_idx = idx;
    end
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
    end while (!(queue.size() == 0 && idle_o) && cycles < 5000);
    if (cycles >= 5000) begin
      $display("timeout: miss queue was not drained in test %s", name);
      timed_out = 1'b1;
    end else begin
      finish_test(name, err0);
    end
  endtask

  initial begin
    clk_i = 1'b0;
    reset_i = 1'b1;
    {miss_v_i, miss_addr_i, miss_write_i, miss_data_i, miss_block_i, miss_id_i} = '0;
    {tag_valid_i, tag_lock_i, tag_tags_i, lru_bits_i, dirty_i} = '0;
    {dma_cmd_ready_i, dma_done_i, data_ready_i} = '0;
    {exp_way, exp_index, exp_tag, exp_evict_tag, exp_evict, exp_dirty} = '0;
    {in_drain, beat_cnt, rd_idx, dma_busy, bp_en, timed_out} = '0;
    dma_wait = 0;
    errors = 0;
    tests = 0;
    randomize_sets();
    repeat (10) @(posedge clk_i);
    #1 reset_i = 1'b0;
    repeat (3) @(posedge clk_i);
    finish_test("reset", 0);
    run_misses("directed_words", 3, 0);
    run_misses("directed_block", 3, 1);
    run_misses("random_sets", 30, 2);
    bp_en = 1'b1;
    run_misses("backpressure", 30, 2);
    $display("tests run: %0d, failed checks: %0d", tests, errors);
    if (errors == 0 && !timed_out) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  `include "mhu_tb_assertions.svh"

endmodule

// ==== files.f ====
+incdir+verification
verilog/mhu_pkg.sv
verilog/replacement_picker.sv
verilog/miss_drain.sv
verilog/mhu_fsm.sv
verilog/miss_handling_unit.sv
verification/mhu_tb.sv

// ==== Makefile ====
TOP = mhu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '^\*\*\* PASSED \*\*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log
